// ==== common/dcache_consts.svh ====
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// Data word and byte address width
`define DCACHE_WORD_W 32

// Set index width for eight sets per way
`define DCACHE_IDX_W 3

// Tag width that is left of the address after the index, block and byte offsets
`define DCACHE_TAG_W 26

`define DCACHE_WAYS 2

`endif

// ==== common/dcache_pkg.sv ====
`include "dcache_consts.svh"

package dcache_pkg;

  typedef logic [`DCACHE_WORD_W-1:0] word_t;

  // Byte address split into its cache fields
  typedef struct packed {
    logic [`DCACHE_TAG_W-1:0] tag;
    logic [`DCACHE_IDX_W-1:0] idx;
    logic                     blkoff;
    logic [1:0]               bytoff;
  } dcachef_t;

  typedef struct packed {
    logic                     valid;
    logic                     dirty;
    logic [`DCACHE_TAG_W-1:0] tag;
    word_t [1:0]              data;
  } dcache_frame_t;

  // Command from the controller to one way
  typedef struct packed {
    dcachef_t addr;
    logic     clear_valid;
    logic     set_valid;
    logic     clear_dirty;
    logic     set_dirty;
    logic     write_tag;
    logic     wen;
    word_t    wdat;
  } frame_ctrl_t;

  typedef struct packed {
    logic     ren;
    logic     wen;
    logic     halt;
    dcachef_t addr;
    word_t    store;
  } core_req_t;

  typedef struct packed {
    logic  dhit;
    word_t load;
    logic  flushed;
  } core_rsp_t;

  typedef struct packed {
    logic  dren;
    logic  dwen;
    logic  cctrans;
    logic  ccwrite;
    word_t daddr;
    word_t dstore;
  } bus_req_t;

  typedef struct packed {
    logic     dwait;
    word_t    dload;
    logic     ccwait;
    logic     ccinv;
    dcachef_t ccsnoopaddr;
  } bus_rsp_t;

endpackage

// ==== dcache/dcache_frame_array.sv ====
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_frame_array
  import dcache_pkg::*;
(
  input  logic          CLK,
  input  logic          nRST,
  input  frame_ctrl_t   ctrl,
  input  dcachef_t      snoopaddr,
  output logic          hit,
  output dcache_frame_t hitframe,
  output logic          snoophit,
  output dcache_frame_t snoopframe
);

  localparam int N_SETS = 1 << `DCACHE_IDX_W;

  logic [N_SETS-1:0]        valid;
  logic [N_SETS-1:0]        dirty;
  logic [`DCACHE_TAG_W-1:0] tags [N_SETS];
  word_t [1:0]              data [N_SETS];

  // State bits of each frame
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      valid <= '0;
      dirty <= '0;
    end
    else
    begin
      if (ctrl.clear_valid)
        valid[ctrl.addr.idx] <= 1'b0;
      else if (ctrl.set_valid)
        valid[ctrl.addr.idx] <= 1'b1;

      if (ctrl.clear_dirty)
        dirty[ctrl.addr.idx] <= 1'b0;
      else if (ctrl.set_dirty)
        dirty[ctrl.addr.idx] <= 1'b1;
    end
  end

  always_ff @(posedge CLK)
  begin
    if (ctrl.write_tag)
      tags[ctrl.addr.idx] <= ctrl.addr.tag;
    if (ctrl.wen)
      data[ctrl.addr.idx][ctrl.addr.blkoff] <= ctrl.wdat; // One word of the block
  end

  // Two independent lookups, one for the core side and one for the snoop side
  assign hitframe = '{
    valid: valid[ctrl.addr.idx],
    dirty: dirty[ctrl.addr.idx],
    tag:   tags[ctrl.addr.idx],
    data:  data[ctrl.addr.idx]
  };

  assign snoopframe = '{
    valid: valid[snoopaddr.idx],
    dirty: dirty[snoopaddr.idx],
    tag:   tags[snoopaddr.idx],
    data:  data[snoopaddr.idx]
  };

  assign hit      = hitframe.valid && (hitframe.tag == ctrl.addr.tag);
  assign snoophit = snoopframe.valid && (snoopframe.tag == snoopaddr.tag);

endmodule

// ==== dcache/dcache_flush_counter.sv ====
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_flush_counter (
  input  logic                     CLK,
  input  logic                     nRST,
  input  logic                     step,
  output logic                     way,
  output logic [`DCACHE_IDX_W-1:0] idx,
  output logic                     last
);

  localparam int WAY_W = $clog2(`DCACHE_WAYS);
  localparam int CNT_W = WAY_W + `DCACHE_IDX_W;

  logic [CNT_W-1:0] cnt;

  // Frame number during a flush walk
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      cnt <= '0;
    else if (step)
      cnt <= cnt + 1'b1;
  end

  // Both ways of a set are visited before moving on
  assign way  = cnt[0];
  assign idx  = cnt[CNT_W-1:WAY_W];
  assign last = &cnt; // Sixteenth frame

endmodule

// ==== dcache/dcache_ctrl.sv ====
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_ctrl
  import dcache_pkg::*;
(
  input  logic                     CLK,
  input  logic                     nRST,
  input  core_req_t                req,
  output core_rsp_t                rsp,
  output bus_req_t                 bus_out,
  input  bus_rsp_t                 bus_in,
  output frame_ctrl_t              ctrl0,
  output frame_ctrl_t              ctrl1,
  input  logic                     hit0,
  input  logic                     hit1,
  input  logic                     snoophit0,
  input  logic                     snoophit1,
  input  dcache_frame_t            frame0,
  input  dcache_frame_t            frame1,
  input  dcache_frame_t            snoopframe0,
  input  dcache_frame_t            snoopframe1,
  input  logic                     flush_way,
  input  logic [`DCACHE_IDX_W-1:0] flush_idx,
  input  logic                     flush_last,
  output logic                     flush_step
);

  localparam int N_SETS = 1 << `DCACHE_IDX_W;

  typedef enum logic [4:0] {
    IDLE, CHOOSE_EVICT, EVICT_WB1, EVICT_WB2,
    BUSRD1, BUSRD2, BUSRDX1, BUSRDX2,
    QUICK_READ, QUICK_WRITE,
    SNOOP_MISS, SNOOP_HIT_M1, SNOOP_HIT_M2, SNOOP_HIT_S1, SNOOP_HIT_S2,
    CHECK_FRAME_DIRTY, FLUSH_WB1, FLUSH_WB2, FLUSHED
  } state_t;

  state_t              state, nxt_state, snoop_state;
  logic                way_sel, nxt_way_sel; // Way being hit or filled
  logic                snoop_way;
  logic                flush_done;
  logic [N_SETS-1:0]   lru, nxt_lru;
  frame_ctrl_t [1:0]   fc;
  dcache_frame_t [1:0] fr, sfr;
  logic [1:0]          hit, shit;
  logic                snoop_entry, beat_done, victim;
  dcache_frame_t       sel_frame, snp_frame;
  dcachef_t            snp_addr;

  function automatic dcachef_t blk_addr(input logic [`DCACHE_TAG_W-1:0] tag,
                                        input logic [`DCACHE_IDX_W-1:0] idx,
                                        input logic                     blkoff);
    dcachef_t a;
    a.tag    = tag;
    a.idx    = idx;
    a.blkoff = blkoff;
    a.bytoff = 2'b00;
    return a;
  endfunction

  assign hit       = {hit1, hit0};
  assign shit      = {snoophit1, snoophit0};
  assign fr        = {frame1, frame0};
  assign sfr       = {snoopframe1, snoopframe0};
  assign ctrl0     = fc[0];
  assign ctrl1     = fc[1];
  assign sel_frame = fr[way_sel];
  assign snp_frame = sfr[snoop_way];
  assign snp_addr  = bus_in.ccsnoopaddr;

  // Snoops only break in where no bus beat has been given away yet
  assign snoop_entry = bus_in.ccwait && (state inside {IDLE, CHOOSE_EVICT, EVICT_WB1,
                       BUSRD1, BUSRDX1, CHECK_FRAME_DIRTY, FLUSH_WB1, FLUSHED});
  assign beat_done = ~bus_in.dwait && !snoop_entry;

  always_comb
  begin
    if (!fr[0].valid)
      victim = 1'b0;
    else if (!fr[1].valid)
      victim = 1'b1;
    else
      victim = lru[req.addr.idx];
  end

  always_comb
  begin
    snoop_state = SNOOP_MISS;
    if ((shit[0] && sfr[0].dirty) || (shit[1] && sfr[1].dirty))
      snoop_state = SNOOP_HIT_M1;
    else if (|shit)
      snoop_state = SNOOP_HIT_S1;
  end

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      state      <= IDLE;
      way_sel    <= 1'b0;
      snoop_way  <= 1'b0;
      flush_done <= 1'b0;
      lru        <= '0;
    end
    else
    begin
      state   <= nxt_state;
      way_sel <= nxt_way_sel;
      lru     <= nxt_lru;
      if (snoop_entry)
        snoop_way <= ~shit[0];
      if (nxt_state == FLUSHED)
        flush_done <= 1'b1; // Held through any later snoop
    end
  end

  always_comb
  begin
    nxt_state   = state;
    nxt_way_sel = way_sel;
    if (snoop_entry)
      nxt_state = snoop_state;
    else
      case (state)
        IDLE:
        begin
          if (req.halt)
            nxt_state = CHECK_FRAME_DIRTY;
          else if ((req.ren || req.wen) && (|hit))
          begin
            nxt_way_sel = ~hit[0];
            if (req.ren)
              nxt_state = QUICK_READ;
            else if (fr[~hit[0]].dirty)
              nxt_state = QUICK_WRITE;
            else
              nxt_state = BUSRDX1; // Clean line must be claimed exclusive first
          end
          else if (req.ren || req.wen)
            nxt_state = CHOOSE_EVICT;
        end
        CHOOSE_EVICT:
        begin
          nxt_way_sel = victim;
          if (fr[victim].valid && fr[victim].dirty)
            nxt_state = EVICT_WB1;
          else
            nxt_state = req.ren ? BUSRD1 : BUSRDX1;
        end
        EVICT_WB1:    if (beat_done) nxt_state = EVICT_WB2;
        EVICT_WB2:    if (beat_done) nxt_state = req.ren ? BUSRD1 : BUSRDX1;
        BUSRD1:       if (beat_done) nxt_state = BUSRD2;
        BUSRD2:       if (beat_done) nxt_state = IDLE;
        BUSRDX1:      if (beat_done) nxt_state = BUSRDX2;
        BUSRDX2:      if (beat_done) nxt_state = IDLE;
        QUICK_READ:   nxt_state = IDLE;
        QUICK_WRITE:  nxt_state = IDLE;
        SNOOP_MISS:   if (!bus_in.ccwait) nxt_state = IDLE;
        SNOOP_HIT_M1: if (beat_done) nxt_state = SNOOP_HIT_M2;
        SNOOP_HIT_M2: if (beat_done) nxt_state = IDLE;
        SNOOP_HIT_S1: if (beat_done) nxt_state = SNOOP_HIT_S2;
        SNOOP_HIT_S2: if (beat_done) nxt_state = IDLE;
        CHECK_FRAME_DIRTY:
        begin
          if (fr[flush_way].dirty)
            nxt_state = FLUSH_WB1;
          else if (flush_last)
            nxt_state = FLUSHED;
        end
        FLUSH_WB1:    if (beat_done) nxt_state = FLUSH_WB2;
        FLUSH_WB2:    if (beat_done) nxt_state = CHECK_FRAME_DIRTY;
        FLUSHED:      nxt_state = FLUSHED;
        default:      nxt_state = IDLE;
      endcase
  end

  always_comb
  begin
    rsp         = '0;
    rsp.flushed = flush_done;
    bus_out     = '0;
    fc          = '0;
    fc[0].addr  = req.addr;
    fc[1].addr  = req.addr;
    nxt_lru     = lru;
    flush_step  = 1'b0;
    case (state)
      EVICT_WB1, EVICT_WB2:
      begin
        bus_out.cctrans = 1'b1;
        bus_out.dwen    = 1'b1;
        bus_out.daddr   = blk_addr(sel_frame.tag, req.addr.idx, state == EVICT_WB2);
        bus_out.dstore  = sel_frame.data[state == EVICT_WB2];
        if (state == EVICT_WB2 && beat_done)
        begin
          fc[way_sel].clear_valid = 1'b1;
          fc[way_sel].clear_dirty = 1'b1;
        end
      end
      BUSRD1, BUSRD2, BUSRDX1, BUSRDX2:
      begin
        bus_out.cctrans     = 1'b1;
        bus_out.dren        = 1'b1;
        bus_out.ccwrite     = (state == BUSRDX1) || (state == BUSRDX2);
        bus_out.daddr       = blk_addr(req.addr.tag, req.addr.idx,
                                       (state == BUSRD2) || (state == BUSRDX2));
        fc[way_sel].addr    = bus_out.daddr;
        fc[way_sel].wdat    = bus_in.dload;
        if (bus_out.ccwrite && req.addr.blkoff == fc[way_sel].addr.blkoff)
          fc[way_sel].wdat  = req.store; // Merge the store into the fill
        fc[way_sel].wen     = beat_done;
        if (fc[way_sel].addr.blkoff && beat_done)
        begin
          fc[way_sel].write_tag   = 1'b1;
          fc[way_sel].set_valid   = 1'b1;
          fc[way_sel].set_dirty   = bus_out.ccwrite;
          fc[way_sel].clear_dirty = !bus_out.ccwrite;
          rsp.dhit                = 1'b1;
          if (!bus_out.ccwrite)
            rsp.load = req.addr.blkoff ? bus_in.dload : sel_frame.data[0];
          nxt_lru[req.addr.idx]   = ~way_sel;
        end
      end
      QUICK_READ:
      begin
        rsp.dhit              = 1'b1;
        rsp.load              = sel_frame.data[req.addr.blkoff];
        nxt_lru[req.addr.idx] = ~way_sel;
      end
      QUICK_WRITE:
      begin
        fc[way_sel].wen       = 1'b1;
        fc[way_sel].wdat      = req.store;
        rsp.dhit              = 1'b1;
        nxt_lru[req.addr.idx] = ~way_sel;
      end
      SNOOP_HIT_M1, SNOOP_HIT_M2, SNOOP_HIT_S1, SNOOP_HIT_S2:
      begin
        bus_out.cctrans = 1'b1;
        bus_out.ccwrite = (state == SNOOP_HIT_M1) || (state == SNOOP_HIT_M2);
        bus_out.daddr   = blk_addr(snp_addr.tag, snp_addr.idx,
                                   (state == SNOOP_HIT_M2) || (state == SNOOP_HIT_S2));
        bus_out.dstore  = snp_frame.data[bus_out.daddr[2]];
        if (bus_out.daddr[2] && beat_done)
        begin
          fc[snoop_way].addr        = snp_addr;
          fc[snoop_way].clear_dirty = 1'b1; // Memory now holds the block
          fc[snoop_way].clear_valid = bus_in.ccinv;
        end
      end
      CHECK_FRAME_DIRTY:
      begin
        fc[flush_way].addr.idx = flush_idx;
        flush_step = !snoop_entry && !fr[flush_way].dirty && !flush_last;
      end
      FLUSH_WB1, FLUSH_WB2:
      begin
        fc[flush_way].addr.idx = flush_idx;
        bus_out.cctrans        = 1'b1;
        bus_out.dwen           = 1'b1;
        bus_out.daddr          = blk_addr(fr[flush_way].tag, flush_idx, state == FLUSH_WB2);
        bus_out.dstore         = fr[flush_way].data[state == FLUSH_WB2];
        if (state == FLUSH_WB2 && beat_done)
          fc[flush_way].clear_dirty = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

// ==== src/dcache_top.sv ====
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_top
  import dcache_pkg::*;
(
  input  logic      CLK,
  input  logic      nRST,
  input  core_req_t req,
  output core_rsp_t rsp,
  output bus_req_t  bus_out,
  input  bus_rsp_t  bus_in
);

  frame_ctrl_t              ctrl0, ctrl1;
  logic                     hit0, hit1;
  logic                     snoophit0, snoophit1;
  dcache_frame_t            frame0, frame1;
  dcache_frame_t            snoopframe0, snoopframe1;
  logic                     flush_way, flush_last, flush_step;
  logic [`DCACHE_IDX_W-1:0] flush_idx;

  dcache_ctrl i_ctrl (
    .CLK         (CLK),
    .nRST        (nRST),
    .req         (req),
    .rsp         (rsp),
    .bus_out     (bus_out),
    .bus_in      (bus_in),
    .ctrl0       (ctrl0),
    .ctrl1       (ctrl1),
    .hit0        (hit0),
    .hit1        (hit1),
    .snoophit0   (snoophit0),
    .snoophit1   (snoophit1),
    .frame0      (frame0),
    .frame1      (frame1),
    .snoopframe0 (snoopframe0),
    .snoopframe1 (snoopframe1),
    .flush_way   (flush_way),
    .flush_idx   (flush_idx),
    .flush_last  (flush_last),
    .flush_step  (flush_step)
  );

  dcache_flush_counter i_flush_counter (
    .CLK  (CLK),
    .nRST (nRST),
    .step (flush_step),
    .way  (flush_way),
    .idx  (flush_idx),
    .last (flush_last)
  );

  // Both ways see the same snoop address
  dcache_frame_array i_way0 (
    .CLK        (CLK),
    .nRST       (nRST),
    .ctrl       (ctrl0),
    .snoopaddr  (bus_in.ccsnoopaddr),
    .hit        (hit0),
    .hitframe   (frame0),
    .snoophit   (snoophit0),
    .snoopframe (snoopframe0)
  );

  dcache_frame_array i_way1 (
    .CLK        (CLK),
    .nRST       (nRST),
    .ctrl       (ctrl1),
    .snoopaddr  (bus_in.ccsnoopaddr),
    .hit        (hit1),
    .hitframe   (frame1),
    .snoophit   (snoophit1),
    .snoopframe (snoopframe1)
  );

endmodule

// ==== testbench/tb_mem_model.sv ====
`timescale 1ns/1ps
`include "dcache_consts.svh"

module tb_mem_model
  import dcache_pkg::*;
(
  input  logic     CLK,
  input  logic     nRST,
  input  bus_req_t bus_out,
  output bus_rsp_t bus_in,
  input  logic     snoop_go,
  input  dcachef_t snoop_addr,
  input  logic     snoop_inv,
  output logic     snoop_busy
);

  word_t       mem [256];
  logic [15:0] lfsr_q;
  logic        nxt_dwait, nxt_ccwait, nxt_ccinv;
  word_t       nxt_dload;
  dcachef_t    nxt_snoopaddr;
  logic        beat_armed, snoop_end;
  int          wait_left, snoop_age;

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  initial
  begin
    for (int i = 0; i < 256; i++)
      mem[i] = (i << 2) ^ 32'hA5A5A5A5; // Byte address XOR pattern
    lfsr_q        = 16'd26;
    bus_in        = '0;
    bus_in.dwait  = 1'b1;
    nxt_dwait     = 1'b1;
    nxt_ccwait    = 1'b0;
    nxt_ccinv     = 1'b0;
    nxt_dload     = '0;
    nxt_snoopaddr = '0;
    beat_armed    = 1'b0;
    wait_left     = 0;
    snoop_age     = 0;
    snoop_busy    = 1'b0;
  end

  // Bus state is sampled mid-cycle and the answer applied after the next edge
  always @(negedge CLK)
  begin
    snoop_end = 1'b0;
    if (bus_out.cctrans && !bus_in.dwait)
    begin
      if (bus_out.dwen || (bus_out.ccwrite && !bus_out.dren))
        mem[bus_out.daddr[9:2]] = bus_out.dstore;
      snoop_end  = snoop_busy && !bus_out.dren && !bus_out.dwen && bus_out.daddr[2];
      nxt_dwait  = 1'b1;
      beat_armed = 1'b0;
    end
    else if (bus_out.cctrans)
    begin
      if (!beat_armed)
      begin
        wait_left = 0;
        repeat (2)
        begin
          lfsr_q    = lfsr_next(lfsr_q);
          wait_left = wait_left * 2 + int'(lfsr_q[0]);
        end
        beat_armed = 1'b1;
      end
      if (wait_left == 0)
      begin
        nxt_dwait = 1'b0;
        nxt_dload = mem[bus_out.daddr[9:2]];
      end
      else
        wait_left--;
    end
    else
      beat_armed = 1'b0;

    if (snoop_busy)
    begin
      snoop_age++;
      // A miss shows no reply one cycle after the cache has seen ccwait
      if (snoop_end || (snoop_age >= 2 && !bus_out.cctrans))
      begin
        nxt_ccwait = 1'b0;
        snoop_busy = 1'b0;
      end
    end
    else if (snoop_go && nRST)
    begin
      snoop_busy    = 1'b1;
      snoop_age     = 0;
      nxt_ccwait    = 1'b1;
      nxt_ccinv     = snoop_inv;
      nxt_snoopaddr = snoop_addr;
    end
  end

  always @(posedge CLK)
  begin
    #1;
    bus_in.dwait       = nxt_dwait;
    bus_in.dload       = nxt_dload;
    bus_in.ccwait      = nxt_ccwait;
    bus_in.ccinv       = nxt_ccinv;
    bus_in.ccsnoopaddr = nxt_snoopaddr;
  end

endmodule

// ==== testbench/tb_dcache.sv ====
`timescale 1ns/1ps
`include "dcache_consts.svh"

module tb_dcache
  import dcache_pkg::*;
();

  logic      CLK, nRST, snoop_go, snoop_inv, snoop_busy;
  dcachef_t  snoop_addr;
  core_req_t req;
  core_rsp_t rsp;
  bus_req_t  bus_out;
  bus_rsp_t  bus_in;
  word_t     ref_mem [256];
  int        strobe_cycles, rd_beats;
  logic      saw_ccwrite;
  word_t     wb_addr[$], wb_data[$], snp_data[$];

  dcache_top i_dcache_top (.CLK(CLK), .nRST(nRST), .req(req), .rsp(rsp),
                           .bus_out(bus_out), .bus_in(bus_in));

  tb_mem_model i_mem_model (.CLK(CLK), .nRST(nRST), .bus_out(bus_out), .bus_in(bus_in),
                            .snoop_go(snoop_go), .snoop_addr(snoop_addr),
                            .snoop_inv(snoop_inv), .snoop_busy(snoop_busy));

  initial
  begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  // Bus beats complete where dwait is low
  always @(negedge CLK)
  begin
    if (bus_out.cctrans || bus_out.dren || bus_out.dwen)
      strobe_cycles++;
    if (bus_out.ccwrite)
      saw_ccwrite = 1'b1;
    if (bus_out.cctrans && !bus_in.dwait)
    begin
      if (bus_out.dren)
        rd_beats++;
      else if (bus_out.dwen)
      begin
        wb_addr.push_back(bus_out.daddr);
        wb_data.push_back(bus_out.dstore);
      end
      else
        snp_data.push_back(bus_out.dstore);
    end
  end

  function automatic word_t expected_word(input word_t a);
    return ref_mem[a[9:2]];
  endfunction

  function automatic string fail_line(input string msg);
    return $sformatf("[FAIL] %0t ns: %s", $time, msg);
  endfunction

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("SIMULATION FAILED");
    $fatal(1, "Run stopped on error");
  endtask

  task automatic clear_monitor();
    strobe_cycles = 0;
    rd_beats      = 0;
    saw_ccwrite   = 1'b0;
    wb_addr.delete();
    wb_data.delete();
    snp_data.delete();
  endtask

  task automatic core_access(input logic rd, input logic wr, input word_t addr,
                             input word_t data, output word_t load, output int cycles);
    @(posedge CLK);
    #1;
    req.ren   = rd;
    req.wen   = wr;
    req.addr  = addr;
    req.store = data;
    cycles    = 0;
    do
    begin
      @(negedge CLK);
      cycles++;
    end while (!rsp.dhit && cycles < 500);
    if (!rsp.dhit)
      stop_run("The cache never answered a core request with dhit");
    load = rsp.load;
    if (wr)
      ref_mem[addr[9:2]] = data;
    @(posedge CLK);
    #1;
    req = '0;
  endtask

  task automatic read_check(input word_t addr, input string what);
    word_t ld;
    int    cyc;
    core_access(1'b1, 1'b0, addr, '0, ld, cyc);
    assert (ld == expected_word(addr)) else stop_run(fail_line(what));
  endtask

  task automatic run_snoop(input word_t addr, input logic inv);
    int t;
    @(posedge CLK);
    #1;
    snoop_addr = addr;
    snoop_inv  = inv;
    snoop_go   = 1'b1;
    t          = 0;
    do
    begin
      @(posedge CLK);
      t++;
    end while (!snoop_busy && t < 100);
    if (!snoop_busy)
      stop_run("The memory model never started the snoop");
    #1 snoop_go = 1'b0;
    t = 0;
    while (snoop_busy && t < 200)
    begin
      @(posedge CLK);
      t++;
    end
    if (snoop_busy)
      stop_run("The snoop reply never finished");
  endtask

  initial
  begin
    word_t ld;
    int    cyc;
    int    t;
    req        = '0;
    snoop_go   = 1'b0;
    snoop_inv  = 1'b0;
    snoop_addr = '0;
    nRST       = 1'b0;
    for (int i = 0; i < 256; i++)
      ref_mem[i] = (i << 2) ^ 32'hA5A5A5A5;
    clear_monitor();
    repeat (4) @(posedge CLK);
    #1 nRST = 1'b1;
    assert (!rsp.dhit && !rsp.flushed && !bus_out.dren && !bus_out.dwen && !bus_out.cctrans)
      else stop_run(fail_line("strobes after reset"));

    clear_monitor();
    read_check(32'h004, "read miss data");
    assert (rd_beats == 2) else stop_run(fail_line("read miss without bus reads"));
    clear_monitor();
    core_access(1'b1, 1'b0, 32'h004, '0, ld, cyc);
    assert (ld == expected_word(32'h004) && strobe_cycles == 0 && cyc == 2)
      else stop_run(fail_line("read hit value, bus activity or latency"));

    clear_monitor();
    core_access(1'b0, 1'b1, 32'h004, 32'h1111_0004, ld, cyc);
    assert (saw_ccwrite && rd_beats == 2) else stop_run(fail_line("clean write not exclusive"));
    read_check(32'h004, "word after clean write");
    read_check(32'h000, "other word of the block");
    clear_monitor();
    core_access(1'b0, 1'b1, 32'h004, 32'h2222_0004, ld, cyc);
    assert (cyc == 2 && strobe_cycles == 0) else stop_run(fail_line("dirty write hit latency"));

    // Way 0 holds the dirty block, way 1 fills next and way 0 becomes the LRU victim
    read_check(32'h044, "second tag of set 0");
    clear_monitor();
    read_check(32'h084, "third tag of set 0");
    assert (wb_addr.size() == 2 && wb_addr[0] == 32'h000 && wb_addr[1] == 32'h004 &&
            wb_data[0] == expected_word(32'h000) && wb_data[1] == expected_word(32'h004))
      else stop_run(fail_line("victim writeback"));
    read_check(32'h004, "evicted block read back");

    core_access(1'b0, 1'b1, 32'h10C, 32'h3333_010C, ld, cyc);
    clear_monitor();
    run_snoop(32'h10C, 1'b0);
    assert (saw_ccwrite && snp_data.size() == 2 && snp_data[0] == expected_word(32'h108) &&
            snp_data[1] == expected_word(32'h10C)) else stop_run(fail_line("modified snoop"));
    clear_monitor();
    run_snoop(32'h10C, 1'b0);
    assert (!saw_ccwrite && snp_data.size() == 2 && snp_data[0] == expected_word(32'h108) &&
            snp_data[1] == expected_word(32'h10C)) else stop_run(fail_line("shared snoop"));
    run_snoop(32'h10C, 1'b1);
    clear_monitor();
    read_check(32'h10C, "read after invalidating snoop");
    assert (rd_beats == 2) else stop_run(fail_line("no refill after invalidation"));

    core_access(1'b0, 1'b1, 32'h0D0, 32'h4444_00D0, ld, cyc);
    core_access(1'b0, 1'b1, 32'h004, 32'h5555_0004, ld, cyc);
    core_access(1'b0, 1'b1, 32'h3F8, 32'h6666_03F8, ld, cyc);
    clear_monitor();
    @(posedge CLK);
    #1 req.halt = 1'b1;
    t = 0;
    do
    begin
      @(negedge CLK);
      t++;
    end while (!rsp.flushed && t < 2000);
    if (!rsp.flushed)
      stop_run("The cache never raised flushed after halt");
    assert (wb_addr.size() == 6) else stop_run(fail_line("flush writeback count"));
    foreach (wb_addr[k])
      assert (wb_addr[k] inside {32'h000, 32'h004, 32'h0D0, 32'h0D4, 32'h3F8, 32'h3FC} &&
              wb_data[k] == expected_word(wb_addr[k])) else stop_run(fail_line("flush beat"));
    repeat (5)
    begin
      @(negedge CLK);
      assert (rsp.flushed) else stop_run(fail_line("flushed dropped"));
    end
    for (int i = 0; i < 256; i++)
      assert (i_mem_model.mem[i] == ref_mem[i]) else stop_run(fail_line("memory after flush"));

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+common
common/dcache_pkg.sv
dcache/dcache_frame_array.sv
dcache/dcache_flush_counter.sv
dcache/dcache_ctrl.sv
src/dcache_top.sv
testbench/tb_mem_model.sv
testbench/tb_dcache.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the data cache testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f src.f --top-module tb_dcache -o sim_dcache

output=$(./obj_dir/sim_dcache 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q "SIMULATION PASSED"; then
  exit 0
fi
exit 1
